//--- common/zbt_fifo_pkg.sv
package zbt_fifo_pkg;

   // One FIFO word and one RAM bus half
   localparam int WORD_W = 36;
   localparam int HALF_W = 18;

   // Widest word pointer any RAM_ADDR_W can need
   localparam int PTR_MAX_W = 18;

   typedef logic [HALF_W-1:0] half_t;

   // Upper half goes to the even RAM address
   typedef struct packed {
      half_t upper;
      half_t lower;
   } word_halves_t;

   // A word seen whole at the ports, or as two halves on the RAM side
   typedef union packed {
      logic [WORD_W-1:0] whole;
      word_halves_t      halves;
   } fifo_word_u;

   typedef enum logic [1:0] {
      RAM_IDLE  = 2'd0,
      RAM_WRITE = 2'd1,
      RAM_READ  = 2'd2
   } ram_op_e;

   // One command per cycle from the sequencer to the bus pipe
   // phase is 0 for the upper half, 1 for the lower half
   typedef struct packed {
      ram_op_e              op;
      logic                 phase;
      logic [PTR_MAX_W-1:0] ptr;
   } ram_cmd_t;

endpackage

//--- verilog/short_fifo.sv
module short_fifo
   import zbt_fifo_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       clear,
   input  fifo_word_u data_in,
   input  logic       write,
   output logic       full,
   output fifo_word_u data_out,
   input  logic       read,
   output logic       empty,
   output logic [4:0] occupied,
   output logic [4:0] space
);

   localparam int DEPTH = 16;
   localparam int IDX_W = 4;

   fifo_word_u       mem [DEPTH];
   logic [IDX_W-1:0] wr_idx;
   logic [IDX_W-1:0] rd_idx;
   logic [IDX_W:0]   count;
   logic             do_write;
   logic             do_read;

   // Strobes against a full or empty FIFO are dropped
   assign do_write = write & ~full;
   assign do_read  = read & ~empty;

   assign full     = (count == 5'(DEPTH));
   assign empty    = (count == '0);
   assign occupied = count;
   assign space    = 5'(DEPTH) - count;

   // Head of the FIFO is always visible
   assign data_out = mem[rd_idx];

   always_ff @(posedge clk)
   begin
      if (do_write)
         mem[wr_idx] <= data_in;
   end

   always_ff @(posedge clk)
   begin
      if (rst || clear)
      begin
         wr_idx <= '0;
         rd_idx <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_write)
            wr_idx <= wr_idx + 1'b1;
         if (do_read)
            rd_idx <= rd_idx + 1'b1;
         case ({do_write, do_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- zbt_fifo/zbt_sequencer.sv
module zbt_sequencer
   import zbt_fifo_pkg::*;
#(
   parameter int RAM_ADDR_W = 19
)
(
   input  logic       clk,
   input  logic       rst,
   input  logic       clear,
   input  logic       in_empty,
   input  logic [4:0] in_occupied,
   input  logic       out_full,
   input  logic [4:0] out_space,
   output logic       in_pop,
   output ram_cmd_t   cmd
);

   // Word pointers leave out the half-select bit
   localparam int PTR_W     = RAM_ADDR_W - 1;
   localparam int RAM_WORDS = 2 ** PTR_W;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WR_UPPER,
      ST_WR_LOWER,
      ST_RD_UPPER,
      ST_RD_LOWER
   } state_e;

   state_e                state;
   state_e                state_next;
   logic [PTR_W-1:0]      wr_ptr;
   logic [PTR_W-1:0]      rd_ptr;
   logic [RAM_ADDR_W-1:0] word_count;
   logic                  ram_full;
   logic                  ram_empty;
   logic [3:0]            rd_hist;
   logic [4:0]            rd_pending;
   logic                  wr_state;
   logic                  rd_state;
   logic                  can_write;
   logic                  can_write_chain;
   logic                  can_read;

   assign ram_full  = (word_count == RAM_ADDR_W'(RAM_WORDS));
   assign ram_empty = (word_count == '0);

   // Read words not yet counted in out_space
   // A word shows up there five cycles after its lower-half state
   always_comb
   begin
      rd_pending = 5'(state == ST_RD_LOWER);
      for (int i = 0; i < 4; i++)
      begin
         rd_pending = rd_pending + 5'(rd_hist[i]);
      end
   end

   assign can_read  = ~ram_empty & ~out_full & (out_space > rd_pending);
   assign can_write = ~ram_full & ~in_empty;

   // The pop of the current word is still in flight in WR_LOWER
   assign can_write_chain = can_write & (in_occupied >= 5'd2);

   always_comb
   begin
      state_next = state;
      case (state)
         ST_IDLE:
         begin
            if (can_read)
               state_next = ST_RD_UPPER;
            else if (can_write)
               state_next = ST_WR_UPPER;
         end
         ST_WR_UPPER:
            state_next = ST_WR_LOWER;
         ST_RD_UPPER:
            state_next = ST_RD_LOWER;
         ST_WR_LOWER,
         ST_RD_LOWER:
         begin
            if (can_read)
               state_next = ST_RD_UPPER;
            else if (can_write_chain)
               state_next = ST_WR_UPPER;
            else
               state_next = ST_IDLE;
         end
         default:
            state_next = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst || clear)
      begin
         state      <= ST_IDLE;
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         word_count <= '0;
         rd_hist    <= '0;
      end
      else
      begin
         state   <= state_next;
         rd_hist <= {rd_hist[2:0], state == ST_RD_LOWER};
         // Count moves on the upper half so the lower state sees it
         if (state == ST_WR_UPPER)
            word_count <= word_count + 1'b1;
         else if (state == ST_RD_UPPER)
            word_count <= word_count - 1'b1;
         if (state == ST_WR_LOWER)
            wr_ptr <= wr_ptr + 1'b1;
         if (state == ST_RD_LOWER)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   assign wr_state = (state == ST_WR_UPPER) || (state == ST_WR_LOWER);
   assign rd_state = (state == ST_RD_UPPER) || (state == ST_RD_LOWER);
   assign in_pop   = (state == ST_WR_LOWER);

   always_comb
   begin
      cmd = '0;
      if (wr_state)
         cmd.op = RAM_WRITE;
      else if (rd_state)
         cmd.op = RAM_READ;
      else
         cmd.op = RAM_IDLE;
      cmd.phase = (state == ST_WR_LOWER) || (state == ST_RD_LOWER);
      cmd.ptr[PTR_W-1:0] = wr_state ? wr_ptr : rd_ptr;
   end

endmodule

//--- zbt_fifo/zbt_bus_pipe.sv
module zbt_bus_pipe
   import zbt_fifo_pkg::*;
#(
   parameter int RAM_ADDR_W = 19
)
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  clear,
   input  ram_cmd_t              cmd,
   input  fifo_word_u            wr_word,
   output logic [RAM_ADDR_W-1:0] ram_addr,
   output logic                  ram_we_n,
   output half_t                 ram_dout,
   output logic                  ram_oe,
   input  half_t                 ram_din,
   output fifo_word_u            out_word,
   output logic                  out_push
);

   // Per-cycle command flags, delayed to the RAM data phase
   typedef struct packed {
      logic wr;
      logic rd;
      logic lower;
   } stage_t;

   stage_t cmd_flags;
   stage_t st_d1;
   stage_t st_d2;
   stage_t st_d3;
   half_t  wr_half_d1;
   half_t  wr_half_d2;

   always_comb
   begin
      cmd_flags.wr    = (cmd.op == RAM_WRITE);
      cmd_flags.rd    = (cmd.op == RAM_READ);
      cmd_flags.lower = cmd.phase;
   end

   // Address cycle is one after the command, data two after that
   always_ff @(posedge clk)
   begin
      ram_addr   <= {cmd.ptr[RAM_ADDR_W-2:0], cmd.phase};
      wr_half_d1 <= cmd.phase ? wr_word.halves.lower : wr_word.halves.upper;
      wr_half_d2 <= wr_half_d1;
      ram_dout   <= wr_half_d2;
   end

   always_ff @(posedge clk)
   begin
      if (rst || clear)
      begin
         ram_we_n <= 1'b1;
         st_d1    <= '0;
         st_d2    <= '0;
         st_d3    <= '0;
         out_push <= 1'b0;
      end
      else
      begin
         ram_we_n <= ~cmd_flags.wr;
         st_d1    <= cmd_flags;
         st_d2    <= st_d1;
         st_d3    <= st_d2;
         // Word is complete once the lower half is in
         out_push <= st_d3.rd & st_d3.lower;
      end
   end

   assign ram_oe = st_d3.wr;

   // Read data is valid in the same stage the write data would be driven
   always_ff @(posedge clk)
   begin
      if (st_d3.rd)
      begin
         if (st_d3.lower)
            out_word.halves.lower <= ram_din;
         else
            out_word.halves.upper <= ram_din;
      end
   end

endmodule

//--- verilog/giant_fifo.sv
module giant_fifo
   import zbt_fifo_pkg::*;
#(
   parameter int RAM_ADDR_W = 19
)
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  clear,
   input  fifo_word_u            data_in,
   input  logic                  write,
   output logic                  full,
   output fifo_word_u            data_out,
   input  logic                  read,
   output logic                  empty,
   output logic [RAM_ADDR_W-1:0] ram_addr,
   output logic                  ram_we_n,
   output half_t                 ram_dout,
   output logic                  ram_oe,
   input  half_t                 ram_din
);

   fifo_word_u in_word;
   logic       in_empty;
   logic [4:0] in_occupied;
   logic       in_pop;
   fifo_word_u out_word;
   logic       out_push;
   logic       out_full;
   logic [4:0] out_space;
   ram_cmd_t   cmd;

   // Writer side staging
   short_fifo u_in_fifo (
      .clk      (clk),
      .rst      (rst),
      .clear    (clear),
      .data_in  (data_in),
      .write    (write),
      .full     (full),
      .data_out (in_word),
      .read     (in_pop),
      .empty    (in_empty),
      .occupied (in_occupied),
      .space    ()
   );

   zbt_sequencer #(.RAM_ADDR_W(RAM_ADDR_W)) u_sequencer (
      .clk         (clk),
      .rst         (rst),
      .clear       (clear),
      .in_empty    (in_empty),
      .in_occupied (in_occupied),
      .out_full    (out_full),
      .out_space   (out_space),
      .in_pop      (in_pop),
      .cmd         (cmd)
   );

   zbt_bus_pipe #(.RAM_ADDR_W(RAM_ADDR_W)) u_bus_pipe (
      .clk      (clk),
      .rst      (rst),
      .clear    (clear),
      .cmd      (cmd),
      .wr_word  (in_word),
      .ram_addr (ram_addr),
      .ram_we_n (ram_we_n),
      .ram_dout (ram_dout),
      .ram_oe   (ram_oe),
      .ram_din  (ram_din),
      .out_word (out_word),
      .out_push (out_push)
   );

   // Reader side, first-word-fall-through
   short_fifo u_out_fifo (
      .clk      (clk),
      .rst      (rst),
      .clear    (clear),
      .data_in  (out_word),
      .write    (out_push),
      .full     (out_full),
      .data_out (data_out),
      .read     (read),
      .empty    (empty),
      .occupied (),
      .space    (out_space)
   );

endmodule

//--- tb/zbt_sram_model.sv
module zbt_sram_model
   import zbt_fifo_pkg::*;
#(
   parameter int ADDR_W = 7
)
(
   input  logic              clk,
   input  logic              rst,
   input  logic [ADDR_W-1:0] ram_addr,
   input  logic              ram_we_n,
   input  half_t             ram_dout,
   input  logic              ram_oe,
   output half_t             ram_din
);

   localparam int DEPTH = 2 ** ADDR_W;

   half_t             mem [DEPTH];
   logic [ADDR_W-1:0] addr_d1;
   logic [ADDR_W-1:0] addr_d2;
   logic              we_d1;
   logic              we_d2;

   // Address pipeline, data phase comes two cycles after the address
   always_ff @(posedge clk)
   begin
      addr_d1 <= ram_addr;
      addr_d2 <= addr_d1;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         we_d1 <= 1'b0;
         we_d2 <= 1'b0;
      end
      else
      begin
         we_d1 <= ~ram_we_n;
         we_d2 <= we_d1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (we_d2 && ram_oe)
         mem[addr_d2] <= ram_dout;
   end

   // Read data valid during the data phase
   assign ram_din = mem[addr_d2];

endmodule

//--- tb/tb_giant_fifo.sv
module tb_giant_fifo
   import zbt_fifo_pkg::*;
();

   localparam int RAM_ADDR_W = 7;
   localparam int RAM_WORDS  = 2 ** (RAM_ADDR_W - 1);
   localparam int FIFO_DEPTH = 16;
   localparam int TIMEOUT    = 2000;

   logic                  clk;
   logic                  rst;
   logic                  clear;
   logic                  write;
   logic                  read;
   logic                  full;
   logic                  empty;
   fifo_word_u            data_in;
   fifo_word_u            data_out;
   logic [RAM_ADDR_W-1:0] ram_addr;
   logic                  ram_we_n;
   logic                  ram_oe;
   half_t                 ram_dout;
   half_t                 ram_din;

   fifo_word_u ref_q [$];
   integer     seed;
   string      test_name;
   int         errors;
   int         checks;
   int         tests_ok;
   int         tests_failed;
   int         errors_at_start;
   int         accept_count;

   // Words waiting to be written into the RAM, oldest first
   fifo_word_u            ram_q [$];
   fifo_word_u            ram_word;
   logic [RAM_ADDR_W-1:0] exp_addr;
   logic                  wr_d1;
   logic                  wr_d2;
   half_t                 half_d1;
   half_t                 half_d2;

   giant_fifo #(.RAM_ADDR_W(RAM_ADDR_W)) u_giant_fifo (
      .clk      (clk),
      .rst      (rst),
      .clear    (clear),
      .data_in  (data_in),
      .write    (write),
      .full     (full),
      .data_out (data_out),
      .read     (read),
      .empty    (empty),
      .ram_addr (ram_addr),
      .ram_we_n (ram_we_n),
      .ram_dout (ram_dout),
      .ram_oe   (ram_oe),
      .ram_din  (ram_din)
   );

   zbt_sram_model #(.ADDR_W(RAM_ADDR_W)) u_sram (
      .clk      (clk),
      .rst      (rst),
      .ram_addr (ram_addr),
      .ram_we_n (ram_we_n),
      .ram_dout (ram_dout),
      .ram_oe   (ram_oe),
      .ram_din  (ram_din)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic fifo_word_u random_word();
      logic [63:0] r;
      fifo_word_u  w;
      r = {$random(seed), $random(seed)};
      w.whole = r[WORD_W-1:0];
      return w;
   endfunction

   // An ideal FIFO returns the oldest accepted word
   function automatic fifo_word_u expected_word();
      return ref_q[0];
   endfunction

   task automatic check_word(input fifo_word_u exp, input fifo_word_u act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("ERROR %s: expected %h, actual %h", test_name, exp.whole, act.whole);
      end
   endtask

   task automatic check_half(input half_t exp, input half_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("ERROR %s (ram_dout): expected %h, actual %h", test_name, exp, act);
      end
   endtask

   task automatic check_addr(input logic [RAM_ADDR_W-1:0] exp,
                             input logic [RAM_ADDR_W-1:0] act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("ERROR %s (ram_addr): expected %h, actual %h", test_name, exp, act);
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("ERROR %s (%s): expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic check_range(input string what, input int lo, input int hi, input int act);
      checks++;
      if (act < lo || act > hi)
      begin
         errors++;
         $display("ERROR %s (%s): expected %0d..%0d, actual %0d", test_name, what, lo, hi, act);
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s: %s", test_name, why);
      $display("sim failed");
      $finish;
   endtask

   task automatic begin_test(input string name);
      test_name       = name;
      errors_at_start = errors;
      accept_count    = 0;
   endtask

   task automatic end_test();
      if (errors == errors_at_start)
      begin
         tests_ok++;
         $display("test %s: ok", test_name);
      end
      else
      begin
         tests_failed++;
         $display("test %s: FAILED, %0d errors", test_name, errors - errors_at_start);
      end
   endtask

   // Holds the word until the write is accepted
   task automatic send_word(input fifo_word_u w);
      int n;
      n = 0;
      @(posedge clk);
      data_in <= w;
      write   <= 1'b1;
      @(negedge clk);
      while (full && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      if (n >= TIMEOUT)
         abort_run("full never dropped while sending a word");
   endtask

   task automatic send_words(input int count);
      for (int i = 0; i < count; i++)
         send_word(random_word());
      @(posedge clk);
      write <= 1'b0;
   endtask

   task automatic wait_not_empty();
      int n;
      n = 0;
      @(negedge clk);
      while (empty && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      if (n >= TIMEOUT)
         abort_run("empty never fell after a write");
   endtask

   task automatic drain_fifo();
      int n;
      n = 0;
      @(posedge clk);
      read <= 1'b1;
      @(negedge clk);
      while (!(empty && ref_q.size() == 0) && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      if (n >= TIMEOUT)
         abort_run("drain did not return every accepted word");
      @(posedge clk);
      read <= 1'b0;
   endtask

   task automatic random_traffic(input int cycles);
      logic [31:0] r;
      for (int i = 0; i < cycles; i++)
      begin
         @(posedge clk);
         r = $random(seed);
         write   <= r[0];
         read    <= r[1];
         data_in <= random_word();
      end
      @(posedge clk);
      write <= 1'b0;
      read  <= 1'b0;
   endtask

   // Keeps writing until full has stayed high for a while
   task automatic fill_until_full();
      int n;
      int high_run;
      n        = 0;
      high_run = 0;
      while (high_run < 32 && n < TIMEOUT)
      begin
         @(posedge clk);
         write   <= 1'b1;
         data_in <= random_word();
         @(negedge clk);
         high_run = full ? high_run + 1 : 0;
         n++;
      end
      @(posedge clk);
      write <= 1'b0;
      if (n >= TIMEOUT)
         abort_run("full never stayed high with the reader stopped");
   endtask

   // Accepted transfers as seen by the DUT on the next rising edge
   always @(negedge clk)
   begin
      if (rst || clear)
         ref_q.delete();
      else
      begin
         if (read && !empty)
         begin
            if (ref_q.size() == 0)
            begin
               errors++;
               $display("%s: the DUT returned a word that was never written", test_name);
            end
            else
            begin
               check_word(expected_word(), data_out);
               void'(ref_q.pop_front());
            end
         end
         if (write && !full)
         begin
            ref_q.push_back(data_in);
            ram_q.push_back(data_in);
            accept_count++;
         end
      end
   end

   // Upper half at the even address, lower half at the odd one,
   // data on the bus two cycles after the address
   always @(negedge clk)
   begin
      if (rst || clear)
      begin
         ram_q.delete();
         exp_addr = '0;
         wr_d1    = 1'b0;
         wr_d2    = 1'b0;
      end
      else
      begin
         check_flag("ram_oe", wr_d2, ram_oe);
         if (wr_d2)
            check_half(half_d2, ram_dout);
         wr_d2   = wr_d1;
         half_d2 = half_d1;
         wr_d1   = !ram_we_n;
         if (!ram_we_n)
         begin
            if (ram_q.size() == 0)
            begin
               errors++;
               half_d1 = '0;
               $display("%s: the DUT wrote the RAM with no word waiting", test_name);
            end
            else
            begin
               check_addr(exp_addr, ram_addr);
               ram_word = ram_q[0];
               half_d1  = exp_addr[0] ? ram_word.halves.lower : ram_word.halves.upper;
               if (exp_addr[0])
                  void'(ram_q.pop_front());
            end
            exp_addr = exp_addr + 1'b1;
         end
      end
   end

   initial
   begin
      seed         = 32'h933d_ed06;
      rst          = 1'b1;
      clear        = 1'b0;
      write        = 1'b0;
      read         = 1'b0;
      data_in      = '0;
      errors       = 0;
      checks       = 0;
      tests_ok     = 0;
      tests_failed = 0;
      test_name    = "reset";
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      begin_test("reset_and_single_word");
      @(negedge clk);
      check_flag("empty", 1'b1, empty);
      check_flag("full", 1'b0, full);
      check_flag("ram_we_n", 1'b1, ram_we_n);
      check_flag("ram_oe", 1'b0, ram_oe);
      send_words(1);
      wait_not_empty();
      drain_fifo();
      end_test();

      begin_test("burst_40");
      send_words(40);
      drain_fifo();
      end_test();

      begin_test("random_traffic_500");
      random_traffic(500);
      drain_fifo();
      end_test();

      begin_test("fill_to_full");
      fill_until_full();
      @(negedge clk);
      check_flag("full", 1'b1, full);
      check_range("accepted words", RAM_WORDS, RAM_WORDS + 2 * FIFO_DEPTH, accept_count);
      drain_fifo();
      end_test();

      begin_test("clear_mid_traffic");
      random_traffic(80);
      @(posedge clk);
      clear <= 1'b1;
      @(posedge clk);
      clear <= 1'b0;
      repeat (10) @(negedge clk);
      check_flag("empty after clear", 1'b1, empty);
      send_words(20);
      drain_fifo();
      end_test();

      $display("tests ok %0d, tests failed %0d, checks %0d, errors %0d",
               tests_ok, tests_failed, checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

//--- src.f
common/zbt_fifo_pkg.sv
verilog/short_fifo.sv
zbt_fifo/zbt_sequencer.sv
zbt_fifo/zbt_bus_pipe.sv
verilog/giant_fifo.sv
tb/zbt_sram_model.sv
tb/tb_giant_fifo.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --timing -j 0 --top-module tb_giant_fifo -f src.f -o tb_giant_fifo; then
   echo "Verilator build failed"
   exit 1
fi

if ! ./obj_dir/tb_giant_fifo > "$log" 2>&1; then
   cat "$log"
   echo "simulation run returned an error status"
   exit 1
fi

cat "$log"

if grep -q "sim failed" "$log"; then
   exit 1
fi

exit 0
